/* verilog/queue_cfg_pkg.sv */
/*
 * Queue configuration defaults
 * Data width and FIFO depths used as parameter defaults by the
 * command queue modules; the top level may override them
 */

package queue_cfg_pkg;

    // Operand and result width
    localparam int DATA_W    = 32;

    // Command FIFO depth, holds CMD_DEPTH-1 commands
    localparam int CMD_DEPTH = 8;

    // Result FIFO depth, kept smaller than the command side
    // so that back-pressure from the host reaches the command FIFO
    localparam int RES_DEPTH = 4;

endpackage : queue_cfg_pkg

/* verilog/op_pkg.sv */
/*
 * Operation definitions
 * Opcode encoding, execute unit states and the width of the
 * opcode field in a command word
 */

package op_pkg;

    // Opcode field width, top bits of a command word
    localparam int OP_W = 2;

    // Arithmetic opcodes
    typedef enum logic [OP_W-1:0] {
        OP_ADD = 2'b00,  // a + b, wraps at data width
        OP_SUB = 2'b01,  // a - b, wraps at data width
        OP_AND = 2'b10,  // Bitwise and
        OP_XOR = 2'b11   // Bitwise xor
    } op_e;

    // Execute unit states
    typedef enum logic {
        EX_IDLE  = 1'b0,  // May issue a pop to the command FIFO
        EX_FETCH = 1'b1   // Command read data valid, push result
    } exec_state_e;

    // Command word layout from top bit down:
    //   opcode [OP_W], operand a [DATA_W], operand b [DATA_W]
    // Total width is OP_W + 2*DATA_W, derived locally in each module

endpackage : op_pkg

/* verilog/fifo_1r1w.sv */
/*
 * Single read / single write FIFO
 * Circular buffer with registered read data, one cycle after a pop,
 * held while pop stays low; one slot is kept free to tell full from empty
 */

`timescale 1ns/1ps

module fifo_1r1w #(
    parameter int DWIDTH = 32,  // Entry width
    parameter int DEPTH  = 8    // Slots, DEPTH-1 usable
) (
    input  logic              i_clk,
    input  logic              i_rst_n,  // Sync, active low

    // Write side
    input  logic              i_push,   // Write at the clock edge
    output logic              o_full,
    input  logic [DWIDTH-1:0] i_wdata,

    // Read side
    input  logic              i_pop,    // Data appears next cycle
    output logic              o_empty,
    output logic [DWIDTH-1:0] o_rdata
);

    // Index width, at least one bit even for a single slot
    localparam int AWIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Last valid index, wrap point for both indices
    localparam logic [AWIDTH-1:0] LAST_IDX = AWIDTH'(DEPTH - 1);

    // One bit wider so DEPTH itself fits for the range check
    localparam logic [AWIDTH:0]   IDX_LIMIT = (AWIDTH + 1)'(DEPTH);

    logic [DWIDTH-1:0] mem [DEPTH];  // Storage, no reset needed

    logic [AWIDTH-1:0] wr_idx;       // Next slot to write
    logic [AWIDTH-1:0] rd_idx;       // Next slot to read
    logic [AWIDTH-1:0] wr_idx_nxt;
    logic [AWIDTH-1:0] rd_idx_nxt;

    // Increment with wrap at an arbitrary depth
    always_comb begin
        wr_idx_nxt = (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
        rd_idx_nxt = (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;
    end

    // Full when one more push would collide with the read index
    assign o_full  = (wr_idx_nxt == rd_idx);
    assign o_empty = (wr_idx == rd_idx);     // Indices equal, nothing stored

    // Index registers
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
        end else begin
            if (i_push) begin
                wr_idx <= wr_idx_nxt;
            end
            if (i_pop) begin
                rd_idx <= rd_idx_nxt;
            end
        end
    end

    // Memory write and registered read
    // Kept apart from the index logic so it can map to block RAM
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_idx] <= i_wdata;
        end
        if (i_pop) begin
            o_rdata <= mem[rd_idx];  // Holds while pop is low
        end
    end

    // Host side must respect the flags
    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_push && o_full)
    ) else $error("fifo_1r1w: push while full");

    a_no_pop_empty: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_pop && o_empty)
    ) else $error("fifo_1r1w: pop while empty");

    // Wrap logic keeps both indices inside the memory
    a_wr_idx_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        {1'b0, wr_idx} < IDX_LIMIT
    ) else $error("fifo_1r1w: write index out of range");

    a_rd_idx_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        {1'b0, rd_idx} < IDX_LIMIT
    ) else $error("fifo_1r1w: read index out of range");

endmodule : fifo_1r1w

/* verilog/op_exec.sv */
/*
 * Execute unit
 * Pops one command at a time from the command FIFO, decodes the
 * opcode and operands and pushes one result into the result FIFO;
 * two cycles per command, only one command in flight
 */

`timescale 1ns/1ps

module op_exec #(
    parameter int DATA_W = queue_cfg_pkg::DATA_W  // Operand and result width
) (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,

    // Command FIFO read side
    input  logic                                 i_cmd_empty,
    output logic                                 o_cmd_pop,
    input  logic [op_pkg::OP_W + 2*DATA_W - 1:0] i_cmd_word,  // Valid in EX_FETCH

    // Result FIFO write side
    input  logic                                 i_res_full,
    output logic                                 o_res_push,
    output logic [DATA_W-1:0]                    o_res_data
);

    import op_pkg::*;

    // Command word width and field positions
    localparam int CMD_W = OP_W + 2*DATA_W;

    exec_state_e state;       // Current state
    exec_state_e next_state;

    op_e               op;    // Decoded opcode
    logic [DATA_W-1:0] opnd_a;
    logic [DATA_W-1:0] opnd_b;

    logic [DATA_W-1:0] sum;   // Truncated to DATA_W
    logic [DATA_W-1:0] diff;  // Truncated to DATA_W
    logic [DATA_W-1:0] result;

    // Issue a pop only when a command waits and the result has room
    // One command in flight, so space checked now is still free at push
    assign o_cmd_pop  = (state == EX_IDLE) && !i_cmd_empty && !i_res_full;

    // Read data from the FIFO is valid in EX_FETCH, push it straight on
    assign o_res_push = (state == EX_FETCH);

    // State sequencing
    always_comb begin
        next_state = state;
        case (state)
            EX_IDLE: begin
                if (o_cmd_pop) begin
                    next_state = EX_FETCH;  // Data arrives next cycle
                end
            end
            EX_FETCH: begin
                next_state = EX_IDLE;       // Result pushed this cycle
            end
            default: begin
                next_state = EX_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= EX_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Unpack the command word, opcode on top
    assign op     = op_e'(i_cmd_word[CMD_W-1 -: OP_W]);
    assign opnd_a = i_cmd_word[2*DATA_W-1 -: DATA_W];
    assign opnd_b = i_cmd_word[DATA_W-1:0];

    // Arithmetic wraps, carry and borrow are dropped
    assign sum  = opnd_a + opnd_b;
    assign diff = opnd_a - opnd_b;

    // Result select
    always_comb begin
        result = sum;
        case (op)
            OP_ADD:  result = sum;
            OP_SUB:  result = diff;
            OP_AND:  result = opnd_a & opnd_b;
            OP_XOR:  result = opnd_a ^ opnd_b;
            default: result = sum;
        endcase
    end

    assign o_res_data = result;

    // Every pop is issued from idle and leads into a fetch cycle
    a_pop_then_fetch: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_cmd_pop |=> (state == EX_FETCH) && ($past(state) == EX_IDLE)
    ) else $error("op_exec: pop outside EX_IDLE");

    // A push only ever follows the pop that fetched its command
    a_push_after_pop: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_res_push |-> (state == EX_FETCH) && $past(o_cmd_pop)
    ) else $error("op_exec: push outside EX_FETCH");

    // Room checked at pop time must still be there at push time
    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_res_push |-> !i_res_full
    ) else $error("op_exec: push while result FIFO full");

endmodule : op_exec

/* verilog/op_queue_top.sv */
/*
 * Arithmetic command queue
 * Host commands go through a command FIFO into the execute unit,
 * results come back through a result FIFO with one cycle read latency
 */

`timescale 1ns/1ps

module op_queue_top #(
    parameter int DATA_W    = queue_cfg_pkg::DATA_W,     // Operand width
    parameter int CMD_DEPTH = queue_cfg_pkg::CMD_DEPTH,  // Command FIFO slots
    parameter int RES_DEPTH = queue_cfg_pkg::RES_DEPTH   // Result FIFO slots
) (
    input  logic              i_clk,
    input  logic              i_rst_n,

    // Command port, sampled at the push edge
    input  logic              i_cmd_push,
    input  op_pkg::op_e       i_cmd_op,
    input  logic [DATA_W-1:0] i_cmd_a,
    input  logic [DATA_W-1:0] i_cmd_b,
    output logic              o_cmd_full,  // Host must not push while high

    // Result port, data valid the cycle after a pop
    input  logic              i_res_pop,
    output logic              o_res_empty, // Host must not pop while high
    output logic [DATA_W-1:0] o_res_data
);

    import op_pkg::*;

    localparam int CMD_W = OP_W + 2*DATA_W;  // Opcode, a, b

    logic [CMD_W-1:0]  cmd_wdata;  // Packed host command
    logic [CMD_W-1:0]  cmd_rdata;  // Command at the FIFO output
    logic              cmd_empty;
    logic              cmd_pop;

    logic              res_full;
    logic              res_push;
    logic [DATA_W-1:0] res_wdata;

    // Opcode in the top bits, then operand a, then operand b
    assign cmd_wdata = {i_cmd_op, i_cmd_a, i_cmd_b};

    fifo_1r1w #(
        .DWIDTH (CMD_W),
        .DEPTH  (CMD_DEPTH)
    ) u_cmd_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_cmd_push),
        .o_full  (o_cmd_full),
        .i_wdata (cmd_wdata),
        .i_pop   (cmd_pop),
        .o_empty (cmd_empty),
        .o_rdata (cmd_rdata)
    );

    op_exec #(
        .DATA_W (DATA_W)
    ) u_exec (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_empty (cmd_empty),
        .o_cmd_pop   (cmd_pop),
        .i_cmd_word  (cmd_rdata),
        .i_res_full  (res_full),
        .o_res_push  (res_push),
        .o_res_data  (res_wdata)
    );

    fifo_1r1w #(
        .DWIDTH (DATA_W),
        .DEPTH  (RES_DEPTH)
    ) u_res_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (res_push),
        .o_full  (res_full),
        .i_wdata (res_wdata),
        .i_pop   (i_res_pop),
        .o_empty (o_res_empty),
        .o_rdata (o_res_data)
    );

endmodule : op_queue_top

/* verification/op_queue_tb.sv */
/*
 * Testbench for the arithmetic command queue
 * Directed, fill and random traffic against a reference model;
 * results checked in push order, with a hold check between pops
 */

`timescale 1ns/1ps

module op_queue_tb;

    import queue_cfg_pkg::*;
    import op_pkg::*;

    localparam int N_DIRECTED     = 6;
    localparam int N_HOLD         = 1;
    localparam int N_FILL         = (CMD_DEPTH - 1) + (RES_DEPTH - 1);  // Both FIFOs full
    localparam int N_RANDOM       = 200;
    localparam int FILL_CYCLES    = 40;
    localparam int CYCLES_PER_CMD = 16;   // Loose bound that covers random gaps
    localparam int MARGIN_CYCLES  = 200;  // Reset, fill settle, drain tails
    localparam int TIMEOUT_CYCLES =
        (N_DIRECTED + N_HOLD + N_FILL + N_RANDOM) * CYCLES_PER_CMD + MARGIN_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              cmd_push;
    op_e               cmd_op;
    logic [DATA_W-1:0] cmd_a;
    logic [DATA_W-1:0] cmd_b;
    logic              cmd_full;
    logic              res_pop;
    logic              res_empty;
    logic [DATA_W-1:0] res_data;

    logic [15:0]       lfsr;                // Galois LFSR state
    logic [DATA_W-1:0] exp_q[$];            // Expected results in push order
    logic [DATA_W-1:0] exp_val;
    logic              pop_seen   = 1'b0;   // Pop sampled at the last edge
    logic              hold_valid = 1'b0;   // A result has been checked
    logic [DATA_W-1:0] hold_val;            // Value o_res_data must keep
    int                n_pushed      = 0;
    int                n_pops        = 0;
    int                n_checked     = 0;
    int                err_data      = 0;
    int                err_hold      = 0;
    int                err_other     = 0;

    op_queue_top u_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_cmd_push  (cmd_push),
        .i_cmd_op    (cmd_op),
        .i_cmd_a     (cmd_a),
        .i_cmd_b     (cmd_b),
        .o_cmd_full  (cmd_full),
        .i_res_pop   (res_pop),
        .o_res_empty (res_empty),
        .o_res_data  (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // One Galois step with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Collect n bits with one LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Reference model where sum and difference wrap at DATA_W
    function automatic logic [DATA_W-1:0] calc_expected(input op_e op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        logic [DATA_W:0] wide;
        case (op)
            OP_ADD: wide = {1'b0, a} + {1'b0, b};       // Carry out dropped below
            OP_SUB: wide = {1'b0, a} + {1'b0, ~b} + 1'b1;  // Two's complement
            OP_AND: wide = {1'b0, a & b};
            default: wide = {1'b0, a ^ b};
        endcase
        return wide[DATA_W-1:0];
    endfunction

    // Every push the DUT samples becomes an expected result
    always @(posedge clk) begin
        if (rst_n && cmd_push) begin
            exp_q.push_back(calc_expected(cmd_op, cmd_a, cmd_b));
            n_pushed++;
        end
        pop_seen <= rst_n && res_pop;
    end

    // Compare at the falling edge when read data has settled
    always @(negedge clk) begin
        if (rst_n && pop_seen) begin
            if (exp_q.size() == 0) begin
                $display("A result was popped with no command outstanding at %0t", $time);
                err_other++;
            end else begin
                exp_val = exp_q.pop_front();
                if (res_data !== exp_val) begin
                    $display("FAIL o_res_data: got %h expected %h at %0t",
                             res_data, exp_val, $time);
                    err_data++;
                end
                hold_val   = exp_val;
                hold_valid = 1'b1;
                n_checked++;
            end
        end else if (rst_n && hold_valid) begin
            if (res_data !== hold_val) begin  // Without a pop the data must not change
                $display("FAIL o_res_data (hold): got %h expected %h at %0t",
                         res_data, hold_val, $time);
                err_hold++;
            end
        end
    end

    // Single-cycle push strobe after the caller has seen o_cmd_full low
    task automatic drive_push(input op_e op, input logic [DATA_W-1:0] a,
                              input logic [DATA_W-1:0] b);
        @(posedge clk);
        cmd_push <= 1'b1;
        cmd_op   <= op;
        cmd_a    <= a;
        cmd_b    <= b;
        @(posedge clk);
        cmd_push <= 1'b0;
    endtask

    task automatic push_cmd(input op_e op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
        @(negedge clk);
        while (cmd_full) begin
            @(negedge clk);
        end
        drive_push(op, a, b);
    endtask

    // Single-cycle pop strobe once a result is waiting
    task automatic pop_result();
        @(negedge clk);
        while (res_empty) begin
            @(negedge clk);
        end
        @(posedge clk);
        res_pop <= 1'b1;
        @(posedge clk);
        res_pop <= 1'b0;
        n_pops++;
    endtask

    task automatic drain_results();
        int n;
        @(negedge clk);             // Last push counted by now
        n = n_pushed - n_pops;
        repeat (n) pop_result();
        repeat (2) @(negedge clk);  // Let the last compare run
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        if (cmd_full !== 1'b0) begin
            $display("FAIL o_cmd_full: got %h expected %h after reset", cmd_full, 1'b0);
            err_data++;
        end
        if (res_empty !== 1'b1) begin
            $display("FAIL o_res_empty: got %h expected %h after reset", res_empty, 1'b1);
            err_data++;
        end
    endtask

    // Every opcode with ADD and SUB across the wrap
    task automatic directed_ops();
        op_e               ops[N_DIRECTED] = '{OP_ADD, OP_ADD, OP_SUB, OP_SUB, OP_AND, OP_XOR};
        logic [DATA_W-1:0] as[N_DIRECTED]  = '{32'hFFFF_FFFF, 32'h1234_5678, 32'h0000_0003,
                                               32'h8000_0000, 32'hF0F0_A5A5, 32'hDEAD_BEEF};
        logic [DATA_W-1:0] bs[N_DIRECTED]  = '{32'h0000_0002, 32'h1111_1111, 32'h0000_0005,
                                               32'h0000_0001, 32'h0FF0_FFFF, 32'hFFFF_0000};
        for (int i = 0; i < N_DIRECTED; i++) begin
            push_cmd(ops[i], as[i], bs[i]);
        end
        drain_results();
    endtask

    // Push whenever there is room without popping and then drain in order
    task automatic fill_and_drain();
        int                start;
        logic [OP_W-1:0]   op_bits;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        start = n_pushed;
        repeat (FILL_CYCLES) begin
            @(negedge clk);
            if (!cmd_full) begin
                op_bits = OP_W'(take_bits(OP_W));
                a       = take_bits(DATA_W);
                b       = take_bits(DATA_W);
                drive_push(op_e'(op_bits), a, b);
            end
        end
        repeat (10) begin  // Stays full while nothing drains
            @(negedge clk);
            if (cmd_full !== 1'b1) begin
                $display("FAIL o_cmd_full: got %h expected %h while full", cmd_full, 1'b1);
                err_data++;
            end
        end
        if (n_pushed - start != N_FILL) begin
            $display("Fill accepted %0d commands instead of %0d", n_pushed - start, N_FILL);
            err_other++;
        end
        drain_results();
    endtask

    // Read data must not move while pop stays low
    task automatic hold_after_pop();
        push_cmd(OP_XOR, 32'h5A5A_5A5A, 32'h0F0F_F0F0);
        pop_result();
        repeat (6) @(negedge clk);  // Compare process checks the held value
    endtask

    // Random push gaps and pop enables with one decision per cycle
    task automatic random_traffic();
        int                sent;
        int                popped;
        int                gap;
        logic              push_now;
        logic              pop_now;
        logic              push_prev;
        logic              pop_prev;
        logic [OP_W-1:0]   op_bits;
        logic [DATA_W-1:0] r_a;
        logic [DATA_W-1:0] r_b;
        sent      = 0;
        popped    = 0;
        gap       = 0;
        push_prev = 1'b0;
        pop_prev  = 1'b0;
        while (sent < N_RANDOM || popped < sent) begin
            @(negedge clk);
            push_now = 1'b0;
            pop_now  = 1'b0;
            if (!push_prev && sent < N_RANDOM) begin  // Flag valid only with strobe low
                if (gap > 0) begin
                    gap--;
                end else if (!cmd_full) begin
                    push_now = 1'b1;
                    op_bits  = OP_W'(take_bits(OP_W));
                    r_a      = take_bits(DATA_W);
                    r_b      = take_bits(DATA_W);
                    gap      = int'(take_bits(2));
                end
            end
            if (!pop_prev && !res_empty) begin
                pop_now = (take_bits(1) != 0);
            end
            @(posedge clk);
            cmd_push <= push_now;
            res_pop  <= pop_now;
            if (push_now) begin
                cmd_op <= op_e'(op_bits);
                cmd_a  <= r_a;
                cmd_b  <= r_b;
                sent++;
            end
            if (pop_now) begin
                popped++;
                n_pops++;
            end
            push_prev = push_now;
            pop_prev  = pop_now;
        end
        @(posedge clk);
        cmd_push <= 1'b0;
        res_pop  <= 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic end_checks();
        @(negedge clk);
        if (res_empty !== 1'b1) begin
            $display("FAIL o_res_empty: got %h expected %h at the end", res_empty, 1'b1);
            err_data++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected results were never returned", exp_q.size());
            err_other++;
        end
        if (n_checked != n_pushed) begin
            $display("Checked %0d results for %0d commands", n_checked, n_pushed);
            err_other++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: data %0d, hold %0d, other %0d; results checked %0d",
                 err_data, err_hold, err_other, n_checked);
        if (err_data + err_hold + err_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        lfsr     = 16'd99;
        rst_n    = 1'b0;
        cmd_push = 1'b0;
        cmd_op   = OP_ADD;
        cmd_a    = '0;
        cmd_b    = '0;
        res_pop  = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        directed_ops();
        fill_and_drain();
        hold_after_pop();
        random_traffic();
        end_checks();
        finish_run();
    end

    // Watchdog sized from the command count
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the queue stopped making progress",
                 TIMEOUT_CYCLES);
        err_other++;
        finish_run();
    end

endmodule : op_queue_tb

/* op_queue.f */
verilog/queue_cfg_pkg.sv
verilog/op_pkg.sv
verilog/fifo_1r1w.sv
verilog/op_exec.sv
verilog/op_queue_top.sv
verification/op_queue_tb.sv

/* Makefile */
# Verilator build and run for the arithmetic command queue

TOP := op_queue_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f op_queue.f -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "Result: FAIL, run ended without a verdict"; exit 1; \
	fi
	@echo "Result: PASS"

clean:
	rm -rf obj_dir $(LOG)
